//--- all.f
+incdir+test
common/scpad_pkg.sv
common/beat_req_if.sv
source/load_requester.sv
source/store_requester.sv
dram_request_queue/dram_request_queue.sv
source/scpad_backend.sv
test/tb_scpad_backend.sv

//--- run_sim.sh
#!/bin/sh
# build the scpad backend testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -f all.f --top-module tb_scpad_backend \
    -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
exit 1

//--- test/tb_scpad_model.svh
`ifndef TB_SCPAD_MODEL_SVH
`define TB_SCPAD_MODEL_SVH

// expected read beats, in the order the load requester sends them
dram_tag_t  exp_load_tag   [$];
dram_addr_t exp_load_addr  [$];
logic       exp_load_write [$];

// expected write beats
dram_tag_t  exp_store_tag   [$];
dram_addr_t exp_store_addr  [$];
logic       exp_store_write [$];

// sram words taken by the store requester, one per write beat
beat_data_t exp_store_data [$];

// one entry per beat of an accepted command
task automatic add_expected_beats(input logic write, input cmd_id_t id,
                                  input dram_addr_t base, input beat_count_t beats);
    dram_tag_t  tag;
    dram_addr_t addr;
    for (int k = 0; k < int'(beats); k++) begin
        // tag is {id, beat}, address steps a full beat
        tag  = {id, sub_id_t'(k)};
        addr = base + dram_addr_t'(BEAT_BYTES * k);
        if (write) begin
            exp_store_tag.push_back(tag);
            exp_store_addr.push_back(addr);
            exp_store_write.push_back(1'b1);
        end else begin
            exp_load_tag.push_back(tag);
            exp_load_addr.push_back(addr);
            exp_load_write.push_back(1'b0);
        end
    end
endtask

// word streamed out of sram
task automatic add_store_word(input beat_data_t word);
    exp_store_data.push_back(word);
endtask

// beats still waiting for their dram issue
function automatic int pending_beats();
    return exp_load_tag.size() + exp_store_tag.size();
endfunction

`endif

//--- test/tb_scpad_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scpad_backend
    import scpad_pkg::*;
();

    localparam int QUEUE_DEPTH     = 4;
    localparam int DRAM_CREDITS    = 3;
    localparam int NUM_CMDS        = 48;
    localparam int STALL_CYCLES    = 40;
    // every command at most 4 beats, 20 cycles per beat, plus slack
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 4 * 20 + 1000;
    // limit for the drain once commands stop
    localparam int DRAIN_CYCLES    = 1000;

    logic        clk;
    logic        n_rst;
    logic        load_cmd_valid;
    logic        load_cmd_ready;
    cmd_id_t     load_cmd_id;
    dram_addr_t  load_cmd_addr;
    beat_count_t load_cmd_beats;
    logic        load_done;
    logic        store_cmd_valid;
    logic        store_cmd_ready;
    cmd_id_t     store_cmd_id;
    dram_addr_t  store_cmd_addr;
    beat_count_t store_cmd_beats;
    logic        store_done;
    beat_data_t  sram_rdata;
    logic        sram_rvalid;
    logic        sram_rready;
    logic        dram_req_valid;
    logic        dram_req_write;
    dram_tag_t   dram_req_tag;
    dram_addr_t  dram_req_addr;
    beat_data_t  dram_req_wdata;
    logic        credit_return;

    // lfsr state, 16 bit fibonacci
    logic [15:0] lfsr_q;

    // handshakes seen at the last negedge, they complete on the next edge
    logic load_taken;
    logic store_taken;
    logic sram_taken;

    int cmds_sent;
    int load_cmds;
    int store_cmds;
    int load_dones;
    int store_dones;
    int outstanding;
    int returns_seen;
    int pre_return_issues;
    int drain_cycles;
    int mismatch_errors;
    int other_errors;

    `include "tb_scpad_model.svh"

    scpad_backend #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .DRAM_CREDITS (DRAM_CREDITS)
    ) i_scpad_backend (
        .clk             (clk),
        .n_rst           (n_rst),
        .load_cmd_valid  (load_cmd_valid),
        .load_cmd_ready  (load_cmd_ready),
        .load_cmd_id     (load_cmd_id),
        .load_cmd_addr   (load_cmd_addr),
        .load_cmd_beats  (load_cmd_beats),
        .load_done       (load_done),
        .store_cmd_valid (store_cmd_valid),
        .store_cmd_ready (store_cmd_ready),
        .store_cmd_id    (store_cmd_id),
        .store_cmd_addr  (store_cmd_addr),
        .store_cmd_beats (store_cmd_beats),
        .store_done      (store_done),
        .sram_rdata      (sram_rdata),
        .sram_rvalid     (sram_rvalid),
        .sram_rready     (sram_rready),
        .dram_req_valid  (dram_req_valid),
        .dram_req_write  (dram_req_write),
        .dram_req_tag    (dram_req_tag),
        .dram_req_addr   (dram_req_addr),
        .dram_req_wdata  (dram_req_wdata),
        .credit_return   (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic rand_bit();
        lfsr_q = lfsr_step(lfsr_q);
        return lfsr_q[0];
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic expect_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_errors++;
            $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // compare the request at the queue head with the model
    task automatic check_issue();
        logic is_store;
        logic have_beat;
        // beat goes to the store stream when it matches that front
        is_store = (exp_store_tag.size() > 0)
                   && (exp_load_tag.size() == 0
                       || (dram_req_tag === exp_store_tag[0]
                           && dram_req_addr === exp_store_addr[0]));
        if (is_store) begin
            have_beat = (exp_store_data.size() > 0);
            assert (have_beat) else begin
                other_errors++;
                $display("store beat issued with no sram word taken for it");
            end
            if (have_beat) begin
                expect_value("dram_req_tag", 64'(dram_req_tag), 64'(exp_store_tag.pop_front()));
                expect_value("dram_req_addr", 64'(dram_req_addr),
                             64'(exp_store_addr.pop_front()));
                expect_value("dram_req_write", 64'(dram_req_write),
                             64'(exp_store_write.pop_front()));
                expect_value("dram_req_wdata", dram_req_wdata, exp_store_data.pop_front());
            end
        end else begin
            have_beat = (exp_load_tag.size() > 0);
            assert (have_beat) else begin
                other_errors++;
                $display("request issued with no load or store beat expected");
            end
            if (have_beat) begin
                expect_value("dram_req_tag", 64'(dram_req_tag), 64'(exp_load_tag.pop_front()));
                expect_value("dram_req_addr", 64'(dram_req_addr), 64'(exp_load_addr.pop_front()));
                expect_value("dram_req_write", 64'(dram_req_write),
                             64'(exp_load_write.pop_front()));
            end
        end
    endtask

    // negedge sample, everything here completes on the coming edge
    task automatic sample_outputs();
        load_taken  = load_cmd_valid && load_cmd_ready;
        store_taken = store_cmd_valid && store_cmd_ready;
        sram_taken  = sram_rvalid && sram_rready;
        if (load_taken) begin
            add_expected_beats(1'b0, load_cmd_id, load_cmd_addr, load_cmd_beats);
            load_cmds++;
        end
        if (store_taken) begin
            add_expected_beats(1'b1, store_cmd_id, store_cmd_addr, store_cmd_beats);
            store_cmds++;
        end
        if (sram_taken) begin
            add_store_word(sram_rdata);
        end
        if (load_done) begin
            load_dones++;
            assert (load_dones <= load_cmds) else begin
                other_errors++;
                $display("load_done pulsed more often than load commands were accepted");
            end
        end
        if (store_done) begin
            store_dones++;
            assert (store_dones <= store_cmds) else begin
                other_errors++;
                $display("store_done pulsed more often than store commands were accepted");
            end
        end
        if (dram_req_valid) begin
            check_issue();
            outstanding++;
            if (returns_seen == 0) begin
                pre_return_issues++;
            end
        end
        if (credit_return) begin
            outstanding--;
            returns_seen++;
        end
        assert (outstanding <= DRAM_CREDITS) else begin
            other_errors++;
            $display("%0d requests outstanding with only %0d credits", outstanding, DRAM_CREDITS);
        end
        assert (returns_seen > 0 || pre_return_issues <= DRAM_CREDITS) else begin
            other_errors++;
            $display("request issued with no credit left before any credit return");
        end
    endtask

    // rising edge drive, commands held until the dut takes them
    task automatic drive_inputs(input logic returns_on, input logic cmds_on);
        logic [31:0] r;
        logic [31:0] lo;
        if (load_taken || !load_cmd_valid) begin
            if (cmds_on && cmds_sent < NUM_CMDS && rand_bit()) begin
                r = rand_bits(29);
                load_cmd_valid <= 1'b1;
                load_cmd_id    <= cmd_id_t'(rand_bits(6));
                load_cmd_addr  <= {r[28:0], 3'b000};
                load_cmd_beats <= beat_count_t'(rand_bits(2)) + beat_count_t'(1);
                cmds_sent++;
            end else begin
                load_cmd_valid <= 1'b0;
            end
        end
        if (store_taken || !store_cmd_valid) begin
            if (cmds_on && cmds_sent < NUM_CMDS && rand_bit()) begin
                r = rand_bits(29);
                store_cmd_valid <= 1'b1;
                store_cmd_id    <= cmd_id_t'(rand_bits(6));
                store_cmd_addr  <= {r[28:0], 3'b000};
                store_cmd_beats <= beat_count_t'(rand_bits(2)) + beat_count_t'(1);
                cmds_sent++;
            end else begin
                store_cmd_valid <= 1'b0;
            end
        end
        // sram word held until taken
        if (sram_taken || !sram_rvalid) begin
            r  = rand_bits(32);
            lo = rand_bits(32);
            sram_rvalid <= rand_bit();
            sram_rdata  <= {r, lo};
        end
        // credits only come back for requests still out
        if (returns_on && outstanding > 0) begin
            credit_return <= rand_bit();
        end else begin
            credit_return <= 1'b0;
        end
    endtask

    task automatic run_cycle(input logic returns_on, input logic cmds_on);
        @(posedge clk);
        drive_inputs(returns_on, cmds_on);
        @(negedge clk);
        sample_outputs();
    endtask

    initial begin
        lfsr_q            = 16'd4;
        n_rst             = 1'b0;
        load_cmd_valid    = 1'b0;
        load_cmd_id       = '0;
        load_cmd_addr     = '0;
        load_cmd_beats    = '0;
        store_cmd_valid   = 1'b0;
        store_cmd_id      = '0;
        store_cmd_addr    = '0;
        store_cmd_beats   = '0;
        sram_rdata        = '0;
        sram_rvalid       = 1'b0;
        credit_return     = 1'b0;
        load_taken        = 1'b0;
        store_taken       = 1'b0;
        sram_taken        = 1'b0;
        cmds_sent         = 0;
        load_cmds         = 0;
        store_cmds        = 0;
        load_dones        = 0;
        store_dones       = 0;
        outstanding       = 0;
        returns_seen      = 0;
        pre_return_issues = 0;
        drain_cycles      = 0;
        mismatch_errors   = 0;
        other_errors      = 0;

        repeat (4) @(posedge clk);
        n_rst <= 1'b1;

        // idle outputs out of reset
        @(negedge clk);
        expect_value("dram_req_valid", 64'(dram_req_valid), 64'(0));
        expect_value("load_done", 64'(load_done), 64'(0));
        expect_value("store_done", 64'(store_done), 64'(0));
        expect_value("sram_rready", 64'(sram_rready), 64'(0));
        expect_value("load_cmd_ready", 64'(load_cmd_ready), 64'(1));
        expect_value("store_cmd_ready", 64'(store_cmd_ready), 64'(1));

        // no credit returns, chain fills up behind the credits
        repeat (STALL_CYCLES) run_cycle(1'b0, 1'b1);
        assert (pre_return_issues == DRAM_CREDITS) else begin
            other_errors++;
            $display("%0d requests issued before any credit return, %0d credits held",
                     pre_return_issues, DRAM_CREDITS);
        end

        // random traffic with credit returns
        while (cmds_sent < NUM_CMDS) run_cycle(1'b1, 1'b1);

        // drain, then watch for stray issues
        while ((pending_beats() != 0 || load_cmd_valid || store_cmd_valid)
               && drain_cycles < DRAIN_CYCLES) begin
            run_cycle(1'b1, 1'b0);
            drain_cycles++;
        end
        repeat (20) run_cycle(1'b1, 1'b0);

        expect_value("load_done count", 64'(load_dones), 64'(load_cmds));
        expect_value("store_done count", 64'(store_dones), 64'(store_cmds));
        assert (load_cmds + store_cmds == cmds_sent) else begin
            other_errors++;
            $display("%0d offered commands were never accepted",
                     cmds_sent - load_cmds - store_cmds);
        end
        assert (pending_beats() == 0) else begin
            other_errors++;
            $display("%0d expected beats were never issued", pending_beats());
        end
        assert (exp_store_data.size() == 0) else begin
            other_errors++;
            $display("%0d sram words never went out with a write", exp_store_data.size());
        end

        $display("%0d load and %0d store commands, %0d mismatches, %0d other errors",
                 load_cmds, store_cmds, mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit from the command count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d expected beats pending",
                 WATCHDOG_CYCLES, pending_beats());
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/scpad_backend.sv
`timescale 1ns/1ps
`default_nettype none

module scpad_backend
    import scpad_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH  = 4,
    parameter int unsigned DRAM_CREDITS = 3
) (
    input  wire              clk,
    input  wire              n_rst,
    // load commands
    input  wire              load_cmd_valid,
    output logic             load_cmd_ready,
    input  wire cmd_id_t     load_cmd_id,
    input  wire dram_addr_t  load_cmd_addr,
    input  wire beat_count_t load_cmd_beats,
    output logic             load_done,
    // store commands
    input  wire              store_cmd_valid,
    output logic             store_cmd_ready,
    input  wire cmd_id_t     store_cmd_id,
    input  wire dram_addr_t  store_cmd_addr,
    input  wire beat_count_t store_cmd_beats,
    output logic             store_done,
    // sram read stream for store data
    input  wire beat_data_t  sram_rdata,
    input  wire              sram_rvalid,
    output logic             sram_rready,
    // dram request port, credit based
    output logic             dram_req_valid,
    output logic             dram_req_write,
    output dram_tag_t        dram_req_tag,
    output dram_addr_t       dram_req_addr,
    output beat_data_t       dram_req_wdata,
    input  wire              credit_return
);

    // requester to queue links
    beat_req_if load_req ();
    beat_req_if store_req ();

    load_requester i_load_requester (
        .clk            (clk),
        .n_rst          (n_rst),
        .load_cmd_valid (load_cmd_valid),
        .load_cmd_ready (load_cmd_ready),
        .load_cmd_id    (load_cmd_id),
        .load_cmd_addr  (load_cmd_addr),
        .load_cmd_beats (load_cmd_beats),
        .load_done      (load_done),
        .req            (load_req.requester)
    );

    store_requester i_store_requester (
        .clk             (clk),
        .n_rst           (n_rst),
        .store_cmd_valid (store_cmd_valid),
        .store_cmd_ready (store_cmd_ready),
        .store_cmd_id    (store_cmd_id),
        .store_cmd_addr  (store_cmd_addr),
        .store_cmd_beats (store_cmd_beats),
        .sram_rdata      (sram_rdata),
        .sram_rvalid     (sram_rvalid),
        .sram_rready     (sram_rready),
        .store_done      (store_done),
        .req             (store_req.requester)
    );

    // arbiter, fifo and credits
    dram_request_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .DRAM_CREDITS (DRAM_CREDITS)
    ) i_dram_request_queue (
        .clk            (clk),
        .n_rst          (n_rst),
        .load_req       (load_req.queue),
        .store_req      (store_req.queue),
        .dram_req_valid (dram_req_valid),
        .dram_req_write (dram_req_write),
        .dram_req_tag   (dram_req_tag),
        .dram_req_addr  (dram_req_addr),
        .dram_req_wdata (dram_req_wdata),
        .credit_return  (credit_return)
    );

endmodule

`default_nettype wire

//--- dram_request_queue/dram_request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module dram_request_queue
    import scpad_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH  = 4,
    parameter int unsigned DRAM_CREDITS = 3
) (
    input  wire         clk,
    input  wire         n_rst,
    beat_req_if.queue   load_req,
    beat_req_if.queue   store_req,
    output logic        dram_req_valid,
    output logic        dram_req_write,
    output dram_tag_t   dram_req_tag,
    output dram_addr_t  dram_req_addr,
    output beat_data_t  dram_req_wdata,
    input  wire         credit_return
);

    // depth is a power of two, so pointers wrap on their own
    localparam int unsigned PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W  = PTR_W + 1;
    localparam int unsigned CRED_W = $clog2(DRAM_CREDITS + 1);

    // round robin, high when store won the last grant
    logic last_store_q;
    logic pick_store;
    logic pick_load;
    logic grant_store;
    logic grant_load;

    // entry chosen for the tail
    logic       push;
    logic       push_write;
    dram_tag_t  push_tag;
    dram_addr_t push_addr;
    beat_data_t push_wdata;

    // parallel entry storage
    logic       wr_mem    [QUEUE_DEPTH];
    dram_tag_t  tag_mem   [QUEUE_DEPTH];
    dram_addr_t addr_mem  [QUEUE_DEPTH];
    beat_data_t wdata_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  tail_q;
    logic [CNT_W-1:0]  count_q;
    logic [CRED_W-1:0] credits_q;

    logic fifo_full;
    logic dram_issue;

    assign fifo_full = (count_q == CNT_W'(QUEUE_DEPTH));

    // both valid: the one not served last time wins
    assign pick_store = store_req.valid && (!load_req.valid || !last_store_q);
    assign pick_load  = load_req.valid && !pick_store;

    // no grant at all while full
    assign grant_store = pick_store && !fifo_full;
    assign grant_load  = pick_load && !fifo_full;
    assign push        = grant_store || grant_load;

    assign store_req.grant = grant_store;
    assign load_req.grant  = grant_load;

    // tail mux
    always_comb begin
        if (pick_store) begin
            push_write = store_req.write;
            push_tag   = store_req.tag;
            push_addr  = store_req.addr;
            push_wdata = store_req.wdata;
        end else begin
            push_write = load_req.write;
            push_tag   = load_req.tag;
            push_addr  = load_req.addr;
            push_wdata = load_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wr_mem[tail_q]    <= push_write;
            tag_mem[tail_q]   <= push_tag;
            addr_mem[tail_q]  <= push_addr;
            wdata_mem[tail_q] <= push_wdata;
        end
    end

    // issue needs a head entry and a credit
    assign dram_issue = (count_q != '0) && (credits_q != '0);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            last_store_q <= 1'b0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            credits_q    <= CRED_W'(DRAM_CREDITS);
        end else begin
            if (push) begin
                last_store_q <= grant_store;
                tail_q       <= tail_q + PTR_W'(1);
            end
            if (dram_issue) begin
                head_q <= head_q + PTR_W'(1);
            end

            // push and pop together leave the count alone
            case ({push, dram_issue})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase

            // issue spends a credit, a return pulse gives one back
            case ({dram_issue, credit_return})
                2'b10:   credits_q <= credits_q - CRED_W'(1);
                2'b01:   credits_q <= credits_q + CRED_W'(1);
                default: credits_q <= credits_q;
            endcase
        end
    end

    // head entry straight from storage
    assign dram_req_valid = dram_issue;
    assign dram_req_write = wr_mem[head_q];
    assign dram_req_tag   = tag_mem[head_q];
    assign dram_req_addr  = addr_mem[head_q];
    assign dram_req_wdata = wdata_mem[head_q];

endmodule

`default_nettype wire

//--- source/store_requester.sv
`timescale 1ns/1ps
`default_nettype none

module store_requester
    import scpad_pkg::*;
(
    input  wire              clk,
    input  wire              n_rst,
    input  wire              store_cmd_valid,
    output logic             store_cmd_ready,
    input  wire cmd_id_t     store_cmd_id,
    input  wire dram_addr_t  store_cmd_addr,
    input  wire beat_count_t store_cmd_beats,
    input  wire beat_data_t  sram_rdata,
    input  wire              sram_rvalid,
    output logic             sram_rready,
    output logic             store_done,
    beat_req_if.requester    req
);

    // control state
    req_state_t state_q;
    sub_id_t    sub_q;
    logic       full_q;

    // latched command
    cmd_id_t    id_q;
    sub_id_t    last_sub_q;
    dram_addr_t addr_q;

    // one sram word waiting for its beat
    beat_data_t data_q;

    logic accept;
    logic word_in;
    logic word_held;
    logic beat_granted;
    logic last_beat;

    assign store_cmd_ready = (state_q == idle);
    assign accept          = store_cmd_valid && store_cmd_ready;

    // pull a word only when the holding register is free
    assign sram_rready = (state_q == issue) && !full_q;
    assign word_in     = sram_rvalid && sram_rready;

    // beat is offered only with its data in hand
    assign word_held    = (state_q == issue) && full_q;
    assign beat_granted = word_held && req.grant;
    assign last_beat    = (sub_q == last_sub_q);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= idle;
            sub_q   <= '0;
            full_q  <= 1'b0;
        end else begin
            // word arrives, or the held word leaves with its beat
            if (word_in) begin
                full_q <= 1'b1;
            end else if (beat_granted) begin
                full_q <= 1'b0;
            end

            case (state_q)
                idle: begin
                    if (accept) begin
                        state_q <= issue;
                        sub_q   <= '0;
                    end
                end
                issue: begin
                    if (beat_granted) begin
                        sub_q <= sub_q + sub_id_t'(1);
                        if (last_beat) begin
                            state_q <= idle;
                        end
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // command fields and beat address
    always_ff @(posedge clk) begin
        if (accept) begin
            id_q       <= store_cmd_id;
            last_sub_q <= sub_id_t'(store_cmd_beats - beat_count_t'(1));
            addr_q     <= store_cmd_addr;
        end else if (beat_granted) begin
            addr_q <= addr_q + dram_addr_t'(BEAT_BYTES);
        end
    end

    // capture the streamed word
    always_ff @(posedge clk) begin
        if (word_in) begin
            data_q <= sram_rdata;
        end
    end

    // write beats carry the held word
    assign req.valid = word_held;
    assign req.write = 1'b1;
    assign req.tag   = {id_q, sub_q};
    assign req.addr  = addr_q;
    assign req.wdata = data_q;

    assign store_done = beat_granted && last_beat;

endmodule

`default_nettype wire

//--- source/load_requester.sv
`timescale 1ns/1ps
`default_nettype none

module load_requester
    import scpad_pkg::*;
(
    input  wire              clk,
    input  wire              n_rst,
    input  wire              load_cmd_valid,
    output logic             load_cmd_ready,
    input  wire cmd_id_t     load_cmd_id,
    input  wire dram_addr_t  load_cmd_addr,
    input  wire beat_count_t load_cmd_beats,
    output logic             load_done,
    beat_req_if.requester    req
);

    // control state
    req_state_t state_q;
    sub_id_t    sub_q;

    // latched command
    cmd_id_t    id_q;
    sub_id_t    last_sub_q;
    dram_addr_t addr_q;

    logic accept;
    logic beat_granted;
    logic last_beat;

    // new command only taken while idle
    assign load_cmd_ready = (state_q == idle);
    assign accept         = load_cmd_valid && load_cmd_ready;

    // one beat leaves per grant
    assign beat_granted = (state_q == issue) && req.grant;
    assign last_beat    = (sub_q == last_sub_q);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= idle;
            sub_q   <= '0;
        end else begin
            case (state_q)
                idle: begin
                    if (accept) begin
                        state_q <= issue;
                        sub_q   <= '0;
                    end
                end
                issue: begin
                    if (beat_granted) begin
                        sub_q <= sub_q + sub_id_t'(1);
                        // back to idle after the final beat
                        if (last_beat) begin
                            state_q <= idle;
                        end
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // command fields, then address walks by one beat per grant
    always_ff @(posedge clk) begin
        if (accept) begin
            id_q       <= load_cmd_id;
            last_sub_q <= sub_id_t'(load_cmd_beats - beat_count_t'(1));
            addr_q     <= load_cmd_addr;
        end else if (beat_granted) begin
            addr_q <= addr_q + dram_addr_t'(BEAT_BYTES);
        end
    end

    // read beats, no payload
    assign req.valid = (state_q == issue);
    assign req.write = 1'b0;
    assign req.tag   = {id_q, sub_q};
    assign req.addr  = addr_q;
    assign req.wdata = '0;

    // pulse with the last grant
    assign load_done = beat_granted && last_beat;

endmodule

`default_nettype wire

//--- common/beat_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one beat request, requester to queue
interface beat_req_if
    import scpad_pkg::*;
();

    // handshake, transfer when both high
    logic       valid;
    logic       grant;

    // beat fields, stable while valid and not granted
    logic       write;
    dram_tag_t  tag;
    dram_addr_t addr;
    beat_data_t wdata;

    // load or store requester side
    modport requester (
        output valid,
        output write,
        output tag,
        output addr,
        output wdata,
        input  grant
    );

    // arbiter side
    modport queue (
        input  valid,
        input  write,
        input  tag,
        input  addr,
        input  wdata,
        output grant
    );

endinterface

`default_nettype wire

//--- common/scpad_pkg.sv
`default_nettype none

package scpad_pkg;

    // dram side widths
    localparam int DRAM_ADDR_W = 32;
    localparam int BEAT_DATA_W = 64;

    // command side widths
    localparam int CMD_ID_W     = 6;
    localparam int SUB_ID_W     = 2;
    localparam int DRAM_TAG_W   = CMD_ID_W + SUB_ID_W;
    localparam int BEAT_COUNT_W = 3;

    // address step between consecutive beats, full 8 byte beats only
    localparam int BEAT_BYTES = 8;

    // dram byte address
    typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;
    // one dram beat of payload
    typedef logic [BEAT_DATA_W-1:0] beat_data_t;
    // scratchpad command id
    typedef logic [CMD_ID_W-1:0] cmd_id_t;
    // beat offset inside a command
    typedef logic [SUB_ID_W-1:0] sub_id_t;
    // {cmd id, sub id}
    typedef logic [DRAM_TAG_W-1:0] dram_tag_t;
    // beats per command, 1 to 4
    typedef logic [BEAT_COUNT_W-1:0] beat_count_t;

    // shared by both requesters
    typedef enum logic {
        idle,
        issue
    } req_state_t;

endpackage

`default_nettype wire
